/* hw/result_tx_pkg.sv */
package result_tx_pkg;

    // byte sequencing states of the transmit controller
    typedef enum logic [3:0] {
        idle,
        register_result,
        send_byte_0,
        wait_byte_0,
        send_byte_1,
        wait_byte_1,
        send_byte_2,
        wait_byte_2,
        send_byte_3,
        wait_byte_3,
        tx_done
    } tx_state_t;

    // one-hot operation enables, bit positions
    localparam int op_read_bit = 0;
    localparam int op_sum_bit  = 1;
    localparam int op_avg_bit  = 2;
    localparam int op_euc_bit  = 3;
    localparam int op_man_bit  = 4;
    localparam int op_dot_bit  = 5;

    localparam int enable_width = 6;
    localparam int result_width = 32;

    // cycles spent loading the result before the first byte
    localparam int register_hold_cycles = 4;
    localparam int hold_count_width = $clog2(register_hold_cycles + 1);

    // serial timing, 8N1 frame
    localparam int clocks_per_bit = 16;
    localparam int frame_bits = 10;
    localparam int baud_count_width = $clog2(clocks_per_bit);
    localparam int bit_count_width = $clog2(frame_bits);

endpackage

/* hw/tx_ctrl.sv */
`timescale 1ns/10ps

module tx_ctrl (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   op_done,
    input  logic [result_tx_pkg::enable_width-1:0] enables,
    input  logic                                   tx_busy,
    output logic                                   tx_start,
    output logic                                   register_result,
    output logic                                   send_b0,
    output logic                                   send_b1,
    output logic                                   send_b2,
    output logic                                   send_b3,
    output logic                                   tx_done,
    output logic                                   tx_active
);
    import result_tx_pkg::*;

    tx_state_t state;
    tx_state_t next_state;

    logic [enable_width-1:0]     op_q;
    logic [hold_count_width-1:0] hold_count;
    logic                        op_accept;
    logic                        short_op;
    logic                        three_byte_op;
    logic                        hold_expired;

    assign op_accept = (state == idle) && op_done;

    // byte count classes of the captured operation
    assign short_op      = op_q[op_read_bit] | op_q[op_sum_bit] | op_q[op_avg_bit];
    assign three_byte_op = op_q[op_man_bit];

    assign hold_expired = hold_count == hold_count_width'(register_hold_cycles - 1);

    always_comb begin
        next_state      = state;
        tx_start        = 1'b0;
        register_result = 1'b0;
        send_b0         = 1'b0;
        send_b1         = 1'b0;
        send_b2         = 1'b0;
        send_b3         = 1'b0;
        tx_done         = 1'b0;

        case (state)
            idle: begin
                if (op_done) begin
                    next_state = result_tx_pkg::register_result;
                end
            end
            result_tx_pkg::register_result: begin
                register_result = 1'b1;
                if (hold_expired) begin
                    next_state = send_byte_0;
                end
            end
            send_byte_0: begin
                send_b0    = 1'b1;
                tx_start   = 1'b1;
                next_state = wait_byte_0;
            end
            wait_byte_0: begin
                if (!tx_busy) begin
                    next_state = send_byte_1;
                end
            end
            send_byte_1: begin
                send_b1    = 1'b1;
                tx_start   = 1'b1;
                next_state = wait_byte_1;
            end
            wait_byte_1: begin
                // read, sum and avg stop after two bytes
                if (!tx_busy) begin
                    next_state = short_op ? result_tx_pkg::tx_done : send_byte_2;
                end
            end
            send_byte_2: begin
                send_b2    = 1'b1;
                tx_start   = 1'b1;
                next_state = wait_byte_2;
            end
            wait_byte_2: begin
                // man stops after three
                if (!tx_busy) begin
                    next_state = three_byte_op ? result_tx_pkg::tx_done : send_byte_3;
                end
            end
            send_byte_3: begin
                send_b3    = 1'b1;
                tx_start   = 1'b1;
                next_state = wait_byte_3;
            end
            wait_byte_3: begin
                if (!tx_busy) begin
                    next_state = result_tx_pkg::tx_done;
                end
            end
            result_tx_pkg::tx_done: begin
                tx_done    = 1'b1;
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // counts only while loading, cleared on any state change
    always_ff @(posedge clock) begin
        if (reset) begin
            hold_count <= '0;
        end else if (state != next_state) begin
            hold_count <= '0;
        end else if (state == result_tx_pkg::register_result) begin
            hold_count <= hold_count + 1'b1;
        end
    end

    // operation is frozen once accepted
    always_ff @(posedge clock) begin
        if (reset) begin
            op_q <= '0;
        end else if (op_accept) begin
            op_q <= enables;
        end
    end

    assign tx_active = state != idle;

    a_enables_onehot: assert property (@(posedge clock) disable iff (reset)
        op_accept |-> $onehot(enables));

    // serializer must have finished the previous frame
    a_start_not_busy: assert property (@(posedge clock) disable iff (reset)
        tx_start |-> !tx_busy);

    a_one_strobe: assert property (@(posedge clock) disable iff (reset)
        (tx_start || (|{send_b3, send_b2, send_b1, send_b0}))
            |-> (tx_start && $onehot({send_b3, send_b2, send_b1, send_b0})));

endmodule

/* hw/result_latch.sv */
`timescale 1ns/10ps

module result_latch (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   register_result,
    input  logic [result_tx_pkg::result_width-1:0] result,
    input  logic                                   send_b0,
    input  logic                                   send_b1,
    input  logic                                   send_b2,
    input  logic                                   send_b3,
    output logic [7:0]                             tx_byte
);
    import result_tx_pkg::*;

    logic [result_width-1:0] word_q;
    logic [3:0]              byte_sel;

    // reloads every cycle of the load window
    always_ff @(posedge clock) begin
        if (reset) begin
            word_q <= '0;
        end else if (register_result) begin
            word_q <= result;
        end
    end

    assign byte_sel = {send_b3, send_b2, send_b1, send_b0};

    // byte 0 when no strobe is up
    always_comb begin
        case (byte_sel)
            4'b0010: tx_byte = word_q[15:8];
            4'b0100: tx_byte = word_q[23:16];
            4'b1000: tx_byte = word_q[31:24];
            default: tx_byte = word_q[7:0];
        endcase
    end

    a_strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
        $onehot0(byte_sel));

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic       clock,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       tx_busy
);
    import result_tx_pkg::*;

    logic [frame_bits-1:0]       frame_q;
    logic [baud_count_width-1:0] baud_count;
    logic [bit_count_width-1:0]  bit_count;
    logic                        bit_end;
    logic                        last_bit;

    assign bit_end  = baud_count == baud_count_width'(clocks_per_bit - 1);
    assign last_bit = bit_count == bit_count_width'(frame_bits - 1);

    // frame is stop, data, start from msb to lsb; idle ones shift in behind it
    always_ff @(posedge clock) begin
        if (reset) begin
            tx_busy    <= 1'b0;
            frame_q    <= '1;
            baud_count <= '0;
            bit_count  <= '0;
        end else if (tx_start && !tx_busy) begin
            tx_busy    <= 1'b1;
            frame_q    <= {1'b1, tx_byte, 1'b0};
            baud_count <= '0;
            bit_count  <= '0;
        end else if (tx_busy) begin
            if (bit_end) begin
                baud_count <= '0;
                frame_q    <= {1'b1, frame_q[frame_bits-1:1]};
                bit_count  <= bit_count + 1'b1;
                // stop bit done
                if (last_bit) begin
                    tx_busy <= 1'b0;
                end
            end else begin
                baud_count <= baud_count + 1'b1;
            end
        end
    end

    assign tx = frame_q[0];

    a_idle_high: assert property (@(posedge clock) disable iff (reset)
        !tx_busy |-> tx);

endmodule

/* hw/result_tx.sv */
`timescale 1ns/10ps

module result_tx (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   op_done,
    input  logic [result_tx_pkg::enable_width-1:0] enables,
    input  logic [result_tx_pkg::result_width-1:0] result,
    output logic                                   tx,
    output logic                                   tx_done,
    output logic                                   tx_active
);
    import result_tx_pkg::*;

    logic       register_result;
    logic       send_b0;
    logic       send_b1;
    logic       send_b2;
    logic       send_b3;
    logic       tx_start;
    logic       tx_busy;
    logic [7:0] tx_byte;

    tx_ctrl u_tx_ctrl (
        .clock           (clock),
        .reset           (reset),
        .op_done         (op_done),
        .enables         (enables),
        .tx_busy         (tx_busy),
        .tx_start        (tx_start),
        .register_result (register_result),
        .send_b0         (send_b0),
        .send_b1         (send_b1),
        .send_b2         (send_b2),
        .send_b3         (send_b3),
        .tx_done         (tx_done),
        .tx_active       (tx_active)
    );

    // byte select follows the send strobes in the same cycle
    result_latch u_result_latch (
        .clock           (clock),
        .reset           (reset),
        .register_result (register_result),
        .result          (result),
        .send_b0         (send_b0),
        .send_b1         (send_b1),
        .send_b2         (send_b2),
        .send_b3         (send_b3),
        .tx_byte         (tx_byte)
    );

    uart_tx u_uart_tx (
        .clock    (clock),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* bench/result_tx_tb.sv */
`timescale 1ns/10ps

module result_tx_tb;
    import result_tx_pkg::*;

    typedef logic [7:0] byte_list_t [$];

    localparam int drive_delay  = 1;
    localparam int random_ops   = 40;
    localparam int op_timeout   = 2000;
    localparam int line_timeout = 5000;

    logic                    clock;
    logic                    reset;
    logic                    op_done;
    logic [enable_width-1:0] enables;
    logic [result_width-1:0] result;
    logic                    tx;
    logic                    tx_done;
    logic                    tx_active;

    logic [31:0]             rng_state;
    logic [result_width-1:0] pending_results [$];
    logic [enable_width-1:0] pending_enables [$];
    logic [7:0]              rx_bytes [$];
    logic [result_width-1:0] directed_values [enable_width];
    int                      ops_issued;
    int                      ops_checked;

    result_tx dut (
        .clock     (clock),
        .reset     (reset),
        .op_done   (op_done),
        .enables   (enables),
        .result    (result),
        .tx        (tx),
        .tx_done   (tx_done),
        .tx_active (tx_active)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // two bytes for read, sum, avg; three for man; four for euc, dot
    function automatic byte_list_t reference_bytes(input logic [31:0] value,
                                                   input logic [enable_width-1:0] ops);
        byte_list_t list;
        int         count;
        int         i;
        count = 0;
        if (ops[op_read_bit] || ops[op_sum_bit] || ops[op_avg_bit]) begin
            count = 2;
        end else if (ops[op_man_bit]) begin
            count = 3;
        end else if (ops[op_euc_bit] || ops[op_dot_bit]) begin
            count = 4;
        end
        // least significant byte first
        for (i = 0; i < count; i++) begin
            list.push_back(value[8*i +: 8]);
        end
        return list;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0d ns: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic drive_slot();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        do begin
            drive_slot();
            cycles++;
            if (cycles > op_timeout) begin
                abort_run($sformatf("operation did not finish within %0d cycles, state %s",
                                    op_timeout, dut.u_tx_ctrl.state.name()));
            end
        end while (tx_active);
    endtask

    // call in a drive slot with the controller idle
    task automatic issue_operation(input logic [31:0] value,
                                   input logic [enable_width-1:0] ops);
        result  = value;
        enables = ops;
        op_done = 1'b1;
        pending_results.push_back(value);
        pending_enables.push_back(ops);
        ops_issued++;
        drive_slot();
        op_done = 1'b0;
        repeat (register_hold_cycles) drive_slot();
        // load window is over, inputs no longer matter
        result  = next_random();
        enables = enable_width'(next_random());
    endtask

    task automatic pulse_stray_op_done();
        check_equal(32'(tx_active), 32'd1, "tx_active before stray op_done");
        result  = next_random();
        enables = '0;
        enables[op_read_bit] = 1'b1;
        op_done = 1'b1;
        drive_slot();
        op_done = 1'b0;
    endtask

    task automatic check_quiet_line(input int cycles);
        repeat (cycles) begin
            drive_slot();
            check_equal(32'(tx), 32'd1, "tx while idle");
            check_equal(32'(tx_done), 32'd0, "tx_done while idle");
            check_equal(32'(tx_active), 32'd0, "tx_active while idle");
        end
    endtask

    // samples at falling clock edges, away from the output updates
    task automatic receive_frame();
        logic [7:0] data;
        int         cycles;
        int         i;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > line_timeout) begin
                abort_run("no start bit appeared on the serial line in time");
            end
        end while (tx !== 1'b0);
        repeat (clocks_per_bit / 2) @(negedge clock);
        check_equal(32'(tx), 32'd0, "start bit at its center");
        for (i = 0; i < 8; i++) begin
            repeat (clocks_per_bit) @(negedge clock);
            data[i] = tx;
        end
        repeat (clocks_per_bit) @(negedge clock);
        check_equal(32'(tx), 32'd1, "stop bit at its center");
        rx_bytes.push_back(data);
    endtask

    task automatic wait_for_tx_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > line_timeout) begin
                abort_run("tx_done did not pulse in time");
            end
        end while (tx_done !== 1'b1);
    endtask

    task automatic compare_operation();
        byte_list_t              expected;
        logic [result_width-1:0] value;
        logic [enable_width-1:0] ops;
        int                      i;
        if (pending_results.size() == 0) begin
            abort_run("tx_done pulsed with no operation outstanding");
        end
        value    = pending_results.pop_front();
        ops      = pending_enables.pop_front();
        expected = reference_bytes(value, ops);
        check_equal(32'(rx_bytes.size()), 32'(expected.size()),
                    $sformatf("byte count of operation %0d", ops_checked));
        for (i = 0; i < expected.size(); i++) begin
            check_equal(32'(rx_bytes[i]), 32'(expected[i]),
                        $sformatf("byte %0d of operation %0d", i, ops_checked));
        end
        rx_bytes.delete();
        ops_checked++;
    endtask

    task automatic decode_line();
        forever begin
            receive_frame();
        end
    endtask

    task automatic compare_results();
        forever begin
            wait_for_tx_done();
            compare_operation();
            @(negedge clock);
            check_equal(32'(tx_done), 32'd0, "tx_done one cycle after its pulse");
        end
    endtask

    initial begin
        logic [enable_width-1:0] ops;
        int                      gap;
        int                      idx;
        clock       = 1'b0;
        reset       = 1'b1;
        op_done     = 1'b0;
        enables     = '0;
        result      = '0;
        rng_state   = 32'h8b24;
        ops_issued  = 0;
        ops_checked = 0;
        directed_values = '{32'h5a96_3cf1, 32'h0123_abcd, 32'hfe80_7f01,
                            32'hc4a1_5e37, 32'h9d2b_6e48, 32'h7711_e2d9};

        repeat (16) drive_slot();
        reset = 1'b0;
        fork
            decode_line();
            compare_results();
        join_none

        check_quiet_line(64);

        // each operation once
        for (idx = 0; idx < enable_width; idx++) begin
            ops      = '0;
            ops[idx] = 1'b1;
            issue_operation(directed_values[idx], ops);
            wait_until_idle();
            repeat (3) drive_slot();
        end

        // stray op_done pulses during a four byte transfer
        ops = '0;
        ops[op_euc_bit] = 1'b1;
        issue_operation(32'h8e7d_21b4, ops);
        repeat (20) drive_slot();
        pulse_stray_op_done();
        repeat (200) drive_slot();
        pulse_stray_op_done();
        wait_until_idle();
        ops = '0;
        ops[op_man_bit] = 1'b1;
        issue_operation(32'h3b6a_c905, ops);
        wait_until_idle();

        for (int n = 0; n < random_ops; n++) begin
            gap = int'(next_random() % 24);
            repeat (gap) drive_slot();
            idx      = int'(next_random() % enable_width);
            ops      = '0;
            ops[idx] = 1'b1;
            issue_operation(next_random(), ops);
            wait_until_idle();
        end

        check_quiet_line(200);

        if (ops_checked == ops_issued && pending_results.size() == 0
                && rx_bytes.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run($sformatf("%0d operations issued but %0d checked, %0d bytes left over",
                                ops_issued, ops_checked, rx_bytes.size()));
        end
    end

endmodule

/* result_tx.f */
hw/result_tx_pkg.sv
hw/tx_ctrl.sv
hw/result_latch.sv
hw/uart_tx.sv
hw/result_tx.sv
bench/result_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the result transmit path and its testbench, then run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f result_tx.f \
    --top-module result_tx_tb \
    -o result_tx_sim

./obj_dir/result_tx_sim
